/* dv/n64_bus_tasks.svh */
// N64 bus driver and reference model
// sends pixels on the four-phase bus, tracks the line and frame
// state that the sync bits imply, and computes the expected video
// and status outputs from the config word
`ifndef N64_BUS_TASKS_SVH
`define N64_BUS_TASKS_SVH

logic [31:0] lfsr_state;
int          m_lines;
int          m_prev_frame;
logic        m_vs_prev, m_hs_prev, m_pal, m_i480;

function automatic void model_reset();
  m_lines      = 0;
  m_prev_frame = 0;
  m_vs_prev    = 1'b0;
  m_hs_prev    = 1'b0;
  m_pal        = 1'b0;
  m_i480       = 1'b0;
endfunction

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic [6:0] rand_color();
  logic [6:0] v;
  logic       fb;
  int         i;
  v = '0;
  for (i = 0; i < 7; i++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    v          = {v[5:0], fb};
  end
  return v;
endfunction

// expected 8-bit channel after 16-bit mode, expansion and scanlines
function automatic logic [7:0] ref_channel(
  input logic [6:0]  c,
  input logic [15:0] cfg,
  input logic        odd
);
  logic [6:0] c7;
  int         c8;
  int         str;
  c7 = c;
  if (cfg[ppu_cfg_pkg::CFG_COLOR16_BIT])
    c7 = c & 7'h7c;
  c8  = {24'd0, c7, c7[6]};
  str = (int'(cfg[ppu_cfg_pkg::CFG_SL_STR_LSB +: 4]) + 1) * 16 - 1;
  if (cfg[ppu_cfg_pkg::CFG_SL_EN_BIT] && odd)
    c8 = c8 - (c8 * str) / 256;
  return c8[7:0];
endfunction

function automatic logic [7:0] ref_status(
  input logic [15:0] cfg,
  input logic        det,
  input logic        pal,
  input logic        i480
);
  logic [7:0] s;
  logic [2:0] tgt;
  tgt = cfg[ppu_cfg_pkg::CFG_TARGET_LSB +: 3];
  s   = '0;
  s[ppu_cfg_pkg::ST_DETECTED_BIT]    = det;
  s[ppu_cfg_pkg::ST_PAL_BIT]         = pal;
  s[ppu_cfg_pkg::ST_480I_BIT]        = i480;
  s[ppu_cfg_pkg::ST_LLM_BIT]         = cfg[ppu_cfg_pkg::CFG_LLM_BIT] |
                                       (tgt == ppu_cfg_pkg::TARGET_240P);
  s[ppu_cfg_pkg::ST_TARGET_LSB +: 3] = tgt;
  s[ppu_cfg_pkg::ST_COLOR16_BIT]     = cfg[ppu_cfg_pkg::CFG_COLOR16_BIT];
  return s;
endfunction

// one pixel, sync phase then R, G, B
task automatic send_pixel(input logic vs, input logic hs);
  logic [6:0] r, g, b;
  logic       odd;
  r = rand_color();
  g = rand_color();
  b = rand_color();
  // a vsync fall closes the frame, the line count restarts
  if (vs && !m_vs_prev) begin
    m_pal        = (m_lines > n64_video_pkg::PAL_LINE_THRESHOLD);
    m_i480       = (m_lines != m_prev_frame);
    m_prev_frame = m_lines;
    m_lines      = (hs && !m_hs_prev) ? 1 : 0;
  end else if (hs && !m_hs_prev) begin
    m_lines++;
  end
  m_vs_prev = vs;
  m_hs_prev = hs;
  odd       = m_lines[0];
  exp_q.push_back({vs, hs, ref_channel(r, cur_cfg, odd), ref_channel(g, cur_cfg, odd),
                   ref_channel(b, cur_cfg, odd)});
  // sync nibble active low, clamp and csync held inactive
  tick(1'b0, {3'b000, ~vs, 1'b1, ~hs, 1'b1});
  tick(1'b1, r);
  tick(1'b1, g);
  tick(1'b1, b);
  // DE_o due two cycles after the B phase
  due_q.push_back(cycle_cnt + 2);
endtask

task automatic send_line(input logic first_of_frame);
  int p;
  for (p = 0; p < 8; p++)
    send_pixel(first_of_frame && p == 0, p == 0);
endtask

task automatic send_frame(input int num_lines);
  int l;
  for (l = 0; l < num_lines; l++)
    send_line(l == 0);
endtask

`endif

/* dv/n64_ppu_tb.sv */
// Testbench for the N64 PPU input side
// drives the four-phase bus from a table of config words and frame
// sizes, checks every DE_o pixel and the status word, and prints a
// summary of checks and errors
`timescale 1ns/1ps

module n64_ppu_tb;

  localparam int NUM_TESTS   = 12;
  localparam int DRAIN_LIMIT = 32;

  logic        clk, rst, n_vdsync;
  logic [6:0]  vd_in;
  logic [15:0] cfg_word;
  logic [7:0]  ppu_state;
  logic        vsync, hsync, de;
  logic [23:0] vd_out;

  // stimulus table
  string       tbl_name    [NUM_TESTS];
  logic [15:0] tbl_cfg     [NUM_TESTS];
  int          tbl_lines_a [NUM_TESTS];
  int          tbl_lines_b [NUM_TESTS];
  int          tbl_frames  [NUM_TESTS];

  logic [25:0] exp_q[$];
  int          due_q[$];
  int          cycle_cnt;
  logic [15:0] cur_cfg;
  string       cur_name;
  int          num_checks, num_errors;
  logic        aborted;

  n64_ppu_top u_dut (
    .N64_CLK_i   (clk),
    .rst_i       (rst),
    .nVDSYNC_i   (n_vdsync),
    .VD_i        (vd_in),
    .ConfigSet_i (cfg_word),
    .PPUState_o  (ppu_state),
    .VSYNC_o     (vsync),
    .HSYNC_o     (hsync),
    .DE_o        (de),
    .VD_o        (vd_out)
  );

  `include "n64_bus_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic void set_entry(input int i, input string name, input logic [15:0] cfg,
                                    input int la, input int lb, input int nf);
    tbl_name[i]    = name;
    tbl_cfg[i]     = cfg;
    tbl_lines_a[i] = la;
    tbl_lines_b[i] = lb;
    tbl_frames[i]  = nf;
  endfunction

  // ==============================
  // name, config, lines a / b, frames
  // ==============================
  function automatic void load_table();
    set_entry(0,  "basic_24bit", 16'h0000,   4,   4, 2);
    set_entry(1,  "color16",     16'h0001,   3,   3, 2);
    set_entry(2,  "sl_str0",     16'h0002,   4,   4, 2);
    set_entry(3,  "sl_str7",     16'h001e,   4,   4, 2);
    set_entry(4,  "sl_str15",    16'h003e,   4,   4, 2);
    set_entry(5,  "pal_300",     16'h0000, 300, 300, 2);
    set_entry(6,  "ntsc_20",     16'h0000,  20,  20, 2);
    set_entry(7,  "i480_alt",    16'h0000,  20,  21, 3);
    set_entry(8,  "i480_equal",  16'h0000,  21,  21, 2);
    set_entry(9,  "target_240p", 16'h0040,   2,   2, 2);
    set_entry(10, "llm_bit",     16'h02c0,   2,   2, 2);
    set_entry(11, "c16_sl15",    16'h003f,   3,   3, 2);
  endfunction

  // one clock, drive after the edge and check the pixel output mid-cycle
  task automatic tick(input logic nsync, input logic [6:0] data);
    logic [25:0] exp;
    int          due;
    @(posedge clk);
    cycle_cnt++;
    #2;
    n_vdsync = nsync;
    vd_in    = data;
    cfg_word = cur_cfg;
    @(negedge clk);
    if (de) begin
      if (due_q.size() == 0) begin
        num_errors++;
        $display("test %s: DE_o strobe with no pixel outstanding", cur_name);
      end else begin
        exp = exp_q.pop_front();
        due = due_q.pop_front();
        num_checks++;
        if ({vsync, hsync, vd_out} !== exp) begin
          num_errors++;
          $display("** Error %s: expected %h, actual %h", cur_name, exp,
                   {vsync, hsync, vd_out});
        end
        if (cycle_cnt != due) begin
          num_errors++;
          $display("** Error %s DE_o cycle: expected %0d, actual %0d", cur_name, due,
                   cycle_cnt);
        end
      end
    end
  endtask

  task automatic check_status();
    logic [7:0] exp;
    exp = ref_status(cur_cfg, 1'b1, m_pal, m_i480);
    num_checks++;
    if (ppu_state !== exp) begin
      num_errors++;
      $display("** Error %s status: expected %h, actual %h", cur_name, exp, ppu_state);
    end
  endtask

  // last sync phase lies three ticks back, status word adds two register stages
  task automatic wait_undetected();
    int n;
    n = 0;
    while (ppu_state[ppu_cfg_pkg::ST_DETECTED_BIT] === 1'b1 &&
           n < n64_video_pkg::DETECT_TIMEOUT + 16) begin
      tick(1'b1, 7'h00);
      n++;
    end
    if (ppu_state[ppu_cfg_pkg::ST_DETECTED_BIT] !== 1'b0) begin
      num_errors++;
      aborted = 1'b1;
      $display("timeout in test %s: detected bit still set after %0d idle cycles", cur_name, n);
    end else if (n != n64_video_pkg::DETECT_TIMEOUT - 1) begin
      num_errors++;
      $display("** Error %s detect drop: expected %0d idle cycles, actual %0d", cur_name,
               n64_video_pkg::DETECT_TIMEOUT - 1, n);
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < DRAIN_LIMIT) begin
      tick(1'b1, 7'h00);
      n++;
    end
    if (exp_q.size() > 0) begin
      num_errors++;
      aborted = 1'b1;
      $display("timeout in test %s: %0d pixels never showed up on DE_o", cur_name, exp_q.size());
      exp_q.delete();
      due_q.delete();
    end
  endtask

  task automatic run_entry(input int t);
    int f;
    cur_name = tbl_name[t];
    cur_cfg  = tbl_cfg[t];
    repeat (3) tick(1'b1, 7'h00);
    for (f = 0; f < tbl_frames[t]; f++)
      send_frame((f % 2 == 0) ? tbl_lines_a[t] : tbl_lines_b[t]);
    // next vsync closes the last frame
    send_frame(1);
    check_status();
    wait_undetected();
    drain();
  endtask

  initial begin
    int t;
    rst        = 1'b1;
    n_vdsync   = 1'b1;
    vd_in      = '0;
    cfg_word   = '0;
    cur_cfg    = '0;
    cur_name   = "reset";
    cycle_cnt  = 0;
    num_checks = 0;
    num_errors = 0;
    aborted    = 1'b0;
    lfsr_state = 32'hfbb1_e301;
    model_reset();
    load_table();

    repeat (3) tick(1'b1, 7'h00);
    num_checks++;
    if ({de, vsync, hsync, vd_out, ppu_state} !== '0) begin
      num_errors++;
      $display("** Error reset: expected 0, actual %h", {de, vsync, hsync, vd_out, ppu_state});
    end
    @(posedge clk);
    #2;
    rst = 1'b0;

    // single pixel raises detected, idle drops it
    cur_name = "detect";
    repeat (2) tick(1'b1, 7'h00);
    send_pixel(1'b0, 1'b0);
    check_status();
    wait_undetected();
    drain();

    for (t = 0; t < NUM_TESTS && !aborted; t++)
      run_entry(t);

    $display("checks %0d, errors %0d", num_checks, num_errors);
    if (num_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* n64_ppu.f */
+incdir+dv
verilog/n64_video_pkg.sv
verilog/ppu_cfg_pkg.sv
verilog/vid_stream_if.sv
verilog/n64_vinfo.sv
verilog/n64_vdemux.sv
verilog/scanline_emu.sv
verilog/ppu_cfg.sv
verilog/n64_ppu_top.sv
dv/n64_ppu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the N64 PPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f n64_ppu.f --top-module n64_ppu_tb -o n64_ppu_sim

out=$(./obj_dir/n64_ppu_sim)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

/* verilog/n64_ppu_top.sv */
// N64 post-processing unit, input side
// video info detection, bus demux, scanline emulation and the
// configuration / status register on the N64 clock
`timescale 1ns/1ps

module n64_ppu_top (
  input  logic                                  N64_CLK_i,
  input  logic                                  rst_i,
  input  logic                                  nVDSYNC_i,
  input  logic [n64_video_pkg::COLOR_W_I-1:0]   VD_i,
  input  logic [ppu_cfg_pkg::CFG_W-1:0]         ConfigSet_i,
  output logic [ppu_cfg_pkg::STATE_W-1:0]       PPUState_o,
  output logic                                  VSYNC_o,
  output logic                                  HSYNC_o,
  output logic                                  DE_o,
  output logic [3*n64_video_pkg::COLOR_W_O-1:0] VD_o
);

  logic       detected, pal, i480, odd_line;
  logic       color16, sl_en;
  logic [7:0] sl_str;

  vid_stream_if #(.pixel_t(n64_video_pkg::pix_in_t))  px_demux (.N64_CLK_i(N64_CLK_i));
  vid_stream_if #(.pixel_t(n64_video_pkg::pix_out_t)) px_post  (.N64_CLK_i(N64_CLK_i));

  // ==============================
  // input side
  // ==============================
  n64_vinfo u_vinfo (
    .N64_CLK_i  (N64_CLK_i),
    .rst_i      (rst_i),
    .nVDSYNC_i  (nVDSYNC_i),
    .sync_i     (VD_i[3:0]),
    .detected_o (detected),
    .pal_o      (pal),
    .i480_o     (i480),
    .odd_line_o (odd_line)
  );

  n64_vdemux u_vdemux (
    .N64_CLK_i  (N64_CLK_i),
    .rst_i      (rst_i),
    .nVDSYNC_i  (nVDSYNC_i),
    .VD_i       (VD_i),
    .odd_line_i (odd_line),
    .color16_i  (color16),
    .px_o       (px_demux.src)
  );

  // ==============================
  // post-processing and config
  // ==============================
  scanline_emu u_sl_emu (
    .N64_CLK_i (N64_CLK_i),
    .rst_i     (rst_i),
    .px_i      (px_demux.snk),
    .sl_en_i   (sl_en),
    .sl_str_i  (sl_str),
    .px_o      (px_post.src)
  );

  ppu_cfg u_cfg (
    .N64_CLK_i   (N64_CLK_i),
    .rst_i       (rst_i),
    .ConfigSet_i (ConfigSet_i),
    .detected_i  (detected),
    .pal_i       (pal),
    .i480_i      (i480),
    .color16_o   (color16),
    .sl_en_o     (sl_en),
    .sl_str_o    (sl_str),
    .PPUState_o  (PPUState_o)
  );

  // video out, R in the top byte
  assign DE_o    = px_post.valid;
  assign VSYNC_o = px_post.pix.vsync;
  assign HSYNC_o = px_post.pix.hsync;
  assign VD_o    = {px_post.pix.r, px_post.pix.g, px_post.pix.b};

endmodule

/* verilog/n64_vdemux.sv */
// N64 video bus demux
// splits the four-phase bus (sync, R, G, B) into one pixel per
// sync phase, optionally reducing colors to the 16-bit mode
`timescale 1ns/1ps

module n64_vdemux (
  input  logic                                N64_CLK_i,
  input  logic                                rst_i,
  input  logic                                nVDSYNC_i,
  input  logic [n64_video_pkg::COLOR_W_I-1:0] VD_i,
  input  logic                                odd_line_i,
  input  logic                                color16_i,
  vid_stream_if.src                           px_o
);

  localparam int CW = n64_video_pkg::COLOR_W_I;

  logic [1:0]    phase;
  logic [CW-1:0] color_mask;
  logic          vs_q, hs_q, odd_q;
  logic [CW-1:0] r_q, g_q;

  // 16-bit mode drops the two low bits of each color
  assign color_mask = color16_i ? {{(CW-2){1'b1}}, 2'b00} : {CW{1'b1}};

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      phase      <= 2'd0;
      px_o.valid <= 1'b0;
    end else begin
      px_o.valid <= 1'b0;
      if (!nVDSYNC_i)
        phase <= 2'd1;
      else if (phase != 2'd0)
        phase <= phase + 2'd1;
      // B phase completes the pixel
      if (nVDSYNC_i && phase == 2'd3)
        px_o.valid <= 1'b1;
    end
  end

  // payload capture
  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      vs_q  <= ~VD_i[n64_video_pkg::SYNC_VSYNC_BIT];
      hs_q  <= ~VD_i[n64_video_pkg::SYNC_HSYNC_BIT];
      odd_q <= odd_line_i;
    end else begin
      case (phase)
        2'd1: r_q <= VD_i & color_mask;
        2'd2: g_q <= VD_i & color_mask;
        2'd3: begin
          px_o.pix.vsync    <= vs_q;
          px_o.pix.hsync    <= hs_q;
          px_o.pix.odd_line <= odd_q;
          px_o.pix.r        <= r_q;
          px_o.pix.g        <= g_q;
          px_o.pix.b        <= VD_i & color_mask;
        end
        default: ;
      endcase
    end
  end

endmodule

/* verilog/n64_video_pkg.sv */
// N64 video constants
// bus widths, sync bit positions, detection limits and the
// pixel payload types that travel between the pipeline stages
package n64_video_pkg;

  // color widths on the N64 bus and after expansion
  localparam int COLOR_W_I = 7;
  localparam int COLOR_W_O = 8;

  // sync nibble on VD_i during the sync phase, active low
  localparam int SYNC_VSYNC_BIT = 3;
  localparam int SYNC_HSYNC_BIT = 1;

  // detection limits
  localparam int DETECT_TIMEOUT     = 64;
  localparam int PAL_LINE_THRESHOLD = 290;
  localparam int LINE_CNT_W         = 10;

  // demuxed pixel, syncs active high
  typedef struct packed {
    logic                 vsync;
    logic                 hsync;
    logic                 odd_line;
    logic [COLOR_W_I-1:0] r;
    logic [COLOR_W_I-1:0] g;
    logic [COLOR_W_I-1:0] b;
  } pix_in_t;

  // expanded pixel after post-processing
  typedef struct packed {
    logic                 vsync;
    logic                 hsync;
    logic                 odd_line;
    logic [COLOR_W_O-1:0] r;
    logic [COLOR_W_O-1:0] g;
    logic [COLOR_W_O-1:0] b;
  } pix_out_t;

endpackage

/* verilog/n64_vinfo.sv */
// N64 video info detection
// watches the sync phases of the N64 bus, flags data present,
// PAL (line count per frame) and 480i (alternating line counts),
// and tracks the parity of the current line
`timescale 1ns/1ps

module n64_vinfo (
  input  logic       N64_CLK_i,
  input  logic       rst_i,
  input  logic       nVDSYNC_i,
  input  logic [3:0] sync_i,
  output logic       detected_o,
  output logic       pal_o,
  output logic       i480_o,
  output logic       odd_line_o
);

  localparam int TO_W  = $clog2(n64_video_pkg::DETECT_TIMEOUT);
  localparam int LCN_W = n64_video_pkg::LINE_CNT_W;

  logic              sync_phase;
  logic              vs_fall, hs_fall;
  logic              vs_n_prev, hs_n_prev;
  logic [TO_W-1:0]   idle_cnt;
  logic [LCN_W-1:0]  line_cnt, line_cnt_nxt, frame_lines;

  assign sync_phase = ~nVDSYNC_i;

  // edges against the previous sync phase, syncs are active low
  assign vs_fall = sync_phase & vs_n_prev & ~sync_i[n64_video_pkg::SYNC_VSYNC_BIT];
  assign hs_fall = sync_phase & hs_n_prev & ~sync_i[n64_video_pkg::SYNC_HSYNC_BIT];

  // first line of a new frame starts at 1 if hsync falls with vsync
  always_comb begin
    line_cnt_nxt = line_cnt;
    if (vs_fall)
      line_cnt_nxt = LCN_W'(hs_fall);
    else if (hs_fall)
      line_cnt_nxt = line_cnt + 1'b1;
  end

  assign odd_line_o = line_cnt_nxt[0];

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      vs_n_prev   <= 1'b1;
      hs_n_prev   <= 1'b1;
      idle_cnt    <= '0;
      line_cnt    <= '0;
      frame_lines <= '0;
      detected_o  <= 1'b0;
      pal_o       <= 1'b0;
      i480_o      <= 1'b0;
    end else begin
      line_cnt <= line_cnt_nxt;
      if (sync_phase) begin
        vs_n_prev  <= sync_i[n64_video_pkg::SYNC_VSYNC_BIT];
        hs_n_prev  <= sync_i[n64_video_pkg::SYNC_HSYNC_BIT];
        idle_cnt   <= '0;
        detected_o <= 1'b1;
      end else if (idle_cnt == TO_W'(n64_video_pkg::DETECT_TIMEOUT - 1)) begin
        detected_o <= 1'b0;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
      // frame ended, judge its line count
      if (vs_fall) begin
        pal_o       <= (line_cnt > LCN_W'(n64_video_pkg::PAL_LINE_THRESHOLD));
        i480_o      <= (line_cnt != frame_lines);
        frame_lines <= line_cnt;
      end
    end
  end

endmodule

/* verilog/ppu_cfg.sv */
// PPU configuration register
// splits the host config word into pipeline controls, maps the
// 4-bit scanline strength to 8 bits and packs the status word
`timescale 1ns/1ps

module ppu_cfg (
  input  logic                             N64_CLK_i,
  input  logic                             rst_i,
  input  logic [ppu_cfg_pkg::CFG_W-1:0]    ConfigSet_i,
  input  logic                             detected_i,
  input  logic                             pal_i,
  input  logic                             i480_i,
  output logic                             color16_o,
  output logic                             sl_en_o,
  output logic [7:0]                       sl_str_o,
  output logic [ppu_cfg_pkg::STATE_W-1:0]  PPUState_o
);

  logic [3:0] str4;
  logic [2:0] target;
  logic       llm;

  assign str4   = ConfigSet_i[ppu_cfg_pkg::CFG_SL_STR_LSB +: 4];
  assign target = ConfigSet_i[ppu_cfg_pkg::CFG_TARGET_LSB +: 3];

  // 240p output always runs in low latency mode
  assign llm = ConfigSet_i[ppu_cfg_pkg::CFG_LLM_BIT] | (target == ppu_cfg_pkg::TARGET_240P);

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      color16_o  <= 1'b0;
      sl_en_o    <= 1'b0;
      sl_str_o   <= '0;
      PPUState_o <= '0;
    end else begin
      color16_o <= ConfigSet_i[ppu_cfg_pkg::CFG_COLOR16_BIT];
      sl_en_o   <= ConfigSet_i[ppu_cfg_pkg::CFG_SL_EN_BIT];
      // (s+1)*16-1, 15 wraps to 255
      sl_str_o  <= (({4'd0, str4} + 8'd1) << 4) - 8'd1;

      PPUState_o[ppu_cfg_pkg::ST_DETECTED_BIT]   <= detected_i;
      PPUState_o[ppu_cfg_pkg::ST_PAL_BIT]        <= pal_i;
      PPUState_o[ppu_cfg_pkg::ST_480I_BIT]       <= i480_i;
      PPUState_o[ppu_cfg_pkg::ST_LLM_BIT]        <= llm;
      PPUState_o[ppu_cfg_pkg::ST_TARGET_LSB +: 3] <= target;
      PPUState_o[ppu_cfg_pkg::ST_COLOR16_BIT]    <= ConfigSet_i[ppu_cfg_pkg::CFG_COLOR16_BIT];
    end
  end

endmodule

/* verilog/ppu_cfg_pkg.sv */
// PPU configuration and status layout
// field positions of the configuration word written by the host
// and of the packed status word read back
package ppu_cfg_pkg;

  // ==============================
  // configuration word
  // ==============================
  localparam int CFG_W = 16;

  localparam int CFG_COLOR16_BIT = 0;
  localparam int CFG_SL_EN_BIT   = 1;
  localparam int CFG_SL_STR_LSB  = 2;
  localparam int CFG_TARGET_LSB  = 6;
  localparam int CFG_LLM_BIT     = 9;

  // target resolution codes
  localparam logic [2:0] TARGET_240P = 3'd1;

  // ==============================
  // status word
  // ==============================
  localparam int STATE_W = 8;

  localparam int ST_DETECTED_BIT = 0;
  localparam int ST_PAL_BIT      = 1;
  localparam int ST_480I_BIT     = 2;
  localparam int ST_LLM_BIT      = 3;
  localparam int ST_TARGET_LSB   = 4;
  localparam int ST_COLOR16_BIT  = 7;

endpackage

/* verilog/scanline_emu.sv */
// Horizontal scanline emulation
// expands 7-bit colors to 8 bits and darkens every odd line by the
// configured strength, c - c*str/256; syncs pass straight through
`timescale 1ns/1ps

module scanline_emu (
  input  logic       N64_CLK_i,
  input  logic       rst_i,
  vid_stream_if.snk  px_i,
  input  logic       sl_en_i,
  input  logic [7:0] sl_str_i,
  vid_stream_if.src  px_o
);

  localparam int CWI = n64_video_pkg::COLOR_W_I;
  localparam int CWO = n64_video_pkg::COLOR_W_O;

  logic darken;

  // replicate the msb into the new lsb
  function automatic logic [CWO-1:0] expand(input logic [CWI-1:0] c);
    expand = {c, c[CWI-1]};
  endfunction

  // scale one channel down
  function automatic logic [CWO-1:0] shade(
    input logic [CWI-1:0] c,
    input logic           dark,
    input logic [7:0]     str
  );
    logic [CWO-1:0]   c8;
    logic [CWO+7:0]   prod;
    c8   = expand(c);
    prod = c8 * str;
    if (dark)
      shade = c8 - prod[CWO+7:8];
    else
      shade = c8;
  endfunction

  assign darken = sl_en_i & px_i.pix.odd_line;

  // ==============================
  // output stage
  // ==============================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      px_o.valid <= 1'b0;
      px_o.pix   <= '0;
    end else begin
      px_o.valid <= px_i.valid;
      if (px_i.valid) begin
        px_o.pix.vsync    <= px_i.pix.vsync;
        px_o.pix.hsync    <= px_i.pix.hsync;
        px_o.pix.odd_line <= px_i.pix.odd_line;
        px_o.pix.r        <= shade(px_i.pix.r, darken, sl_str_i);
        px_o.pix.g        <= shade(px_i.pix.g, darken, sl_str_i);
        px_o.pix.b        <= shade(px_i.pix.b, darken, sl_str_i);
      end
    end
  end

endmodule

/* verilog/vid_stream_if.sv */
// Pixel stream
// one-cycle valid strobe with a payload that holds between strobes,
// no back-pressure
`timescale 1ns/1ps

interface vid_stream_if #(
  parameter type pixel_t = logic
) (
  input logic N64_CLK_i
);

  logic   valid;
  pixel_t pix;

  modport src (input N64_CLK_i, output valid, output pix);
  modport snk (input N64_CLK_i, input valid, input pix);

endinterface
